// File: list.f
rtl/rv_exec_pkg.sv
rtl/rv_exec_decode.sv
rtl/rv_arith.sv
rtl/rv_shift.sv
rtl/rv_result.sv
rtl/rv_exec.sv
verification/rv_exec_assert.sv
verification/tb_rv_exec.sv

// File: rtl/rv_arith.sv
/*
 * Adder and magnitude comparator of the execute unit.
 * Operands are picked from the request under decode control; the
 * comparator is a log-depth tree of (lt, eq) pairs.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_arith (
	input  rv_exec_pkg::exec_req_t  req_i,
	input  rv_exec_pkg::exec_ctrl_t ctrl_i,
	output logic [rv_exec_pkg::XLEN-1:0] sum_o,
	output logic [rv_exec_pkg::XLEN-1:0] sumw_o,
	output logic lt_o,
	output logic eq_o
);

	logic [rv_exec_pkg::XLEN-1:0] add_a;
	logic [rv_exec_pkg::XLEN-1:0] add_b;
	logic [rv_exec_pkg::XLEN-1:0] cmp_b;
	// one row per tree level, row 0 is per bit
	logic [rv_exec_pkg::SHAMT_W:0][rv_exec_pkg::XLEN-1:0] lt_t;
	logic [rv_exec_pkg::SHAMT_W:0][rv_exec_pkg::XLEN-1:0] eq_t;

	assign add_a = ctrl_i.add_pc ? {req_i.pc, 1'b0} : req_i.rs1;
	// sub is rs1 + ~rs2 + 1
	assign add_b = ctrl_i.add_imm ? req_i.imm : (ctrl_i.add_inv ? ~req_i.rs2 : req_i.rs2);
	assign sum_o = add_a + add_b + {{(rv_exec_pkg::XLEN-1){1'b0}}, ctrl_i.add_cin};
	assign sumw_o = {{rv_exec_pkg::HALF_W{sum_o[rv_exec_pkg::HALF_W-1]}},
		sum_o[rv_exec_pkg::HALF_W-1:0]};

	assign cmp_b = ctrl_i.cmp_imm ? req_i.imm : req_i.rs2;

	always_comb begin
		lt_t = '0;
		eq_t = '0;
		for (int i = 0; i < rv_exec_pkg::XLEN; i++) begin
			eq_t[0][i] = ~(req_i.rs1[i] ^ cmp_b[i]);
			lt_t[0][i] = ~req_i.rs1[i] & cmp_b[i];
		end
		// sign bit set means smaller when signed
		if (ctrl_i.cmp_signed)
			lt_t[0][rv_exec_pkg::XLEN-1] = req_i.rs1[rv_exec_pkg::XLEN-1] &
				~cmp_b[rv_exec_pkg::XLEN-1];
		// upper half decides unless equal
		for (int l = 1; l <= rv_exec_pkg::SHAMT_W; l++)
			for (int n = 0; n < (rv_exec_pkg::XLEN >> l); n++) begin
				lt_t[l][n] = lt_t[l-1][2*n+1] | (eq_t[l-1][2*n+1] & lt_t[l-1][2*n]);
				eq_t[l][n] = eq_t[l-1][2*n+1] & eq_t[l-1][2*n];
			end
	end

	assign lt_o = lt_t[rv_exec_pkg::SHAMT_W][0];
	assign eq_o = eq_t[rv_exec_pkg::SHAMT_W][0];

endmodule

`default_nettype wire

// File: rtl/rv_exec.sv
/*
 * RV64 integer execute unit, top level.
 * Accepts one instruction per valid_i strobe and returns its response
 * with valid_o exactly one cycle later; no back-pressure.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_exec (
	input  logic clk,
	input  logic rst_i,
	input  logic valid_i,
	input  rv_exec_pkg::exec_req_t req_i,
	output logic valid_o,
	output rv_exec_pkg::exec_resp_t resp_o
);

	rv_exec_pkg::exec_ctrl_t ctrl;
	logic [rv_exec_pkg::XLEN-1:0] sum;
	logic [rv_exec_pkg::XLEN-1:0] sumw;
	logic lt;
	logic eq;
	logic [rv_exec_pkg::XLEN-1:0] sll;
	logic [rv_exec_pkg::XLEN-1:0] sllw;
	logic [rv_exec_pkg::XLEN-1:0] sr;
	logic [rv_exec_pkg::XLEN-1:0] srw;
	// immediate forms shift by imm, register forms by rs2
	wire [rv_exec_pkg::SHAMT_W-1:0] shamt = ctrl.shamt_imm ?
		req_i.imm[rv_exec_pkg::SHAMT_W-1:0] : req_i.rs2[rv_exec_pkg::SHAMT_W-1:0];

	rv_exec_decode i_decode (.req_i(req_i), .ctrl_o(ctrl));

	rv_arith i_arith (.req_i(req_i), .ctrl_i(ctrl), .sum_o(sum), .sumw_o(sumw),
		.lt_o(lt), .eq_o(eq));

	rv_shift i_shift (.value_i(req_i.rs1), .shamt_i(shamt), .arith_i(ctrl.shift_arith),
		.sll_o(sll), .sllw_o(sllw), .sr_o(sr), .srw_o(srw));

	// only registered stage
	rv_result i_result (.clk(clk), .rst_i(rst_i), .valid_i(valid_i), .req_i(req_i),
		.ctrl_i(ctrl), .sum_i(sum), .sumw_i(sumw), .lt_i(lt), .eq_i(eq),
		.sll_i(sll), .sllw_i(sllw), .sr_i(sr), .srw_i(srw),
		.valid_o(valid_o), .resp_o(resp_o));

endmodule

`default_nettype wire

// File: rtl/rv_exec_decode.sv
/*
 * Instruction decode for the execute unit.
 * Turns opcode, funct3, funct7 and the shift immediate into operand
 * selects, the rd source and memory/branch controls; flags sigill.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_exec_decode (
	input  rv_exec_pkg::exec_req_t  req_i,
	output rv_exec_pkg::exec_ctrl_t ctrl_o
);

	always_comb begin
		ctrl_o = '0;
		ctrl_o.rd_sel = rv_exec_pkg::rd_add;
		case (req_i.opcode)
			rv_exec_pkg::opc_load: begin
				// lb..lwu, funct3 7 undefined
				ctrl_o.sigill = &req_i.funct3;
				ctrl_o.add_imm = 1'b1;
				// rd is written by the memory stage, not here
				ctrl_o.mem_load = 1'b1;
			end
			rv_exec_pkg::opc_op_imm: begin
				ctrl_o.add_imm = 1'b1;
				ctrl_o.cmp_imm = 1'b1;
				ctrl_o.shamt_imm = 1'b1;
				ctrl_o.rd_write = 1'b1;
				ctrl_o.cmp_signed = ~req_i.funct3[0];
				ctrl_o.shift_arith = req_i.imm[10];
				case (req_i.funct3)
					3'b000: ctrl_o.rd_sel = rv_exec_pkg::rd_add;
					// slli, upper six imm bits must be zero
					3'b001: begin
						ctrl_o.rd_sel = rv_exec_pkg::rd_sll;
						ctrl_o.sigill = |req_i.imm[11:6];
					end
					3'b010,
					3'b011: ctrl_o.rd_sel = rv_exec_pkg::rd_lt;
					3'b100: ctrl_o.rd_sel = rv_exec_pkg::rd_xor;
					// srli or srai, only imm[10] may be set
					3'b101: begin
						ctrl_o.rd_sel = rv_exec_pkg::rd_sr;
						ctrl_o.sigill = req_i.imm[11] | (|req_i.imm[9:6]);
					end
					3'b110: ctrl_o.rd_sel = rv_exec_pkg::rd_or;
					default: ctrl_o.rd_sel = rv_exec_pkg::rd_and;
				endcase
			end
			rv_exec_pkg::opc_auipc: begin
				ctrl_o.add_pc = 1'b1;
				ctrl_o.add_imm = 1'b1;
				ctrl_o.rd_write = 1'b1;
			end
			rv_exec_pkg::opc_op_imm32: begin
				ctrl_o.add_imm = 1'b1;
				ctrl_o.shamt_imm = 1'b1;
				ctrl_o.rd_write = 1'b1;
				ctrl_o.shift_arith = req_i.imm[10];
				case (req_i.funct3)
					3'b000: ctrl_o.rd_sel = rv_exec_pkg::rd_addw;
					// word shifts take a five bit amount
					3'b001: begin
						ctrl_o.rd_sel = rv_exec_pkg::rd_sllw;
						ctrl_o.sigill = |req_i.imm[11:5];
					end
					3'b101: begin
						ctrl_o.rd_sel = rv_exec_pkg::rd_srw;
						ctrl_o.sigill = req_i.imm[11] | (|req_i.imm[9:5]);
					end
					default: ctrl_o.sigill = 1'b1;
				endcase
			end
			rv_exec_pkg::opc_store: begin
				// sb, sh, sw, sd only
				ctrl_o.sigill = req_i.funct3[2];
				ctrl_o.add_imm = 1'b1;
				ctrl_o.mem_store = 1'b1;
			end
			rv_exec_pkg::opc_op,
			rv_exec_pkg::opc_op32: begin
				ctrl_o.rd_write = 1'b1;
				// sub and sra both carry funct7 bit 5
				ctrl_o.add_inv = req_i.funct7[5];
				ctrl_o.add_cin = req_i.funct7[5];
				ctrl_o.shift_arith = req_i.funct7[5];
				ctrl_o.cmp_signed = ~req_i.funct3[0];
				casez ({req_i.opcode == rv_exec_pkg::opc_op32, req_i.funct3, req_i.funct7})
					11'b0_000_0?00000: ctrl_o.rd_sel = rv_exec_pkg::rd_add;
					11'b0_001_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_sll;
					11'b0_01?_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_lt;
					11'b0_100_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_xor;
					11'b0_101_0?00000: ctrl_o.rd_sel = rv_exec_pkg::rd_sr;
					11'b0_110_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_or;
					11'b0_111_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_and;
					// word forms
					11'b1_000_0?00000: ctrl_o.rd_sel = rv_exec_pkg::rd_addw;
					11'b1_001_0000000: ctrl_o.rd_sel = rv_exec_pkg::rd_sllw;
					11'b1_101_0?00000: ctrl_o.rd_sel = rv_exec_pkg::rd_srw;
					default: ctrl_o.sigill = 1'b1;
				endcase
			end
			rv_exec_pkg::opc_lui: begin
				ctrl_o.rd_sel = rv_exec_pkg::rd_imm;
				ctrl_o.rd_write = 1'b1;
			end
			rv_exec_pkg::opc_branch: begin
				// funct3 010 and 011 are not branches
				ctrl_o.sigill = (req_i.funct3[2:1] == 2'b01);
				ctrl_o.add_pc = 1'b1;
				ctrl_o.add_imm = 1'b1;
				ctrl_o.branch = 1'b1;
				// odd funct3 is the negated condition
				ctrl_o.branch_inv = req_i.funct3[0];
				ctrl_o.branch_lt = req_i.funct3[2];
				ctrl_o.cmp_signed = ~req_i.funct3[1];
			end
			rv_exec_pkg::opc_jalr: begin
				ctrl_o.sigill = |req_i.funct3;
				ctrl_o.add_imm = 1'b1;
				ctrl_o.rd_sel = rv_exec_pkg::rd_link;
				ctrl_o.rd_write = 1'b1;
				ctrl_o.jump = 1'b1;
			end
			rv_exec_pkg::opc_jal: begin
				ctrl_o.add_pc = 1'b1;
				ctrl_o.add_imm = 1'b1;
				ctrl_o.rd_sel = rv_exec_pkg::rd_link;
				ctrl_o.rd_write = 1'b1;
				ctrl_o.jump = 1'b1;
			end
			default: ctrl_o.sigill = 1'b1;
		endcase

		// illegal instructions have no side effects downstream
		if (ctrl_o.sigill) begin
			ctrl_o.rd_write = 1'b0;
			ctrl_o.mem_load = 1'b0;
			ctrl_o.mem_store = 1'b0;
			ctrl_o.branch = 1'b0;
			ctrl_o.jump = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rv_exec_pkg.sv
/*
 * Shared widths, encodings and bundle types of the RV64 execute unit.
 * Every block of the unit refers to these by scoped name; nothing here
 * holds logic.
 */
`default_nettype none

package rv_exec_pkg;

	// register and word widths
	localparam int XLEN = 64;
	localparam int HALF_W = 32;
	// log2 of XLEN, also the comparator tree depth
	localparam int SHAMT_W = 6;
	// pc bit 0 is always zero, not stored
	localparam int PC_W = 63;

	// major opcode, inst[6:2]
	typedef enum logic [4:0] {
		opc_load    = 5'b00000,
		opc_op_imm  = 5'b00100,
		opc_auipc   = 5'b00101,
		opc_op_imm32 = 5'b00110,
		opc_store   = 5'b01000,
		opc_op      = 5'b01100,
		opc_lui     = 5'b01101,
		opc_op32    = 5'b01110,
		opc_branch  = 5'b11000,
		opc_jalr    = 5'b11001,
		opc_jal     = 5'b11011
	} opcode_e;

	// source of rd
	typedef enum logic [3:0] {
		rd_add,
		rd_addw,
		rd_sll,
		rd_sllw,
		rd_sr,
		rd_srw,
		rd_lt,
		rd_and,
		rd_or,
		rd_xor,
		rd_imm,
		rd_link
	} rd_sel_e;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		// already sign-extended by the decoder upstream
		logic [XLEN-1:0] imm;
		logic [PC_W-1:0] pc;
		// pc plus instruction length
		logic [PC_W-1:0] pcnext;
	} exec_req_t;

	typedef struct packed {
		// adder in1 is pc instead of rs1
		logic add_pc;
		// adder in2 is imm, else rs2 or ~rs2
		logic add_imm;
		logic add_inv;
		logic add_cin;
		// second compare/logic operand is imm instead of rs2
		logic cmp_imm;
		logic cmp_signed;
		logic shamt_imm;
		logic shift_arith;
		rd_sel_e rd_sel;
		logic rd_write;
		logic branch;
		logic branch_inv;
		logic branch_lt;
		logic jump;
		logic mem_load;
		logic mem_store;
		logic sigill;
	} exec_ctrl_t;

	typedef struct packed {
		logic sigill;
		logic [XLEN-1:0] rd;
		logic rd_write;
		logic [PC_W-1:0] pcnext;
		logic mem_load;
		logic mem_store;
		logic [2:0] mem_funct3;
		logic [XLEN-1:0] mem_address;
		logic [XLEN-1:0] mem_store_value;
	} exec_resp_t;

endpackage

`default_nettype wire

// File: rtl/rv_result.sv
/*
 * Result stage of the execute unit.
 * Picks rd, resolves branches and jumps, builds the memory request and
 * registers the response one cycle after the valid strobe.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_result (
	input  logic clk,
	input  logic rst_i,
	input  logic valid_i,
	input  rv_exec_pkg::exec_req_t  req_i,
	input  rv_exec_pkg::exec_ctrl_t ctrl_i,
	input  logic [rv_exec_pkg::XLEN-1:0] sum_i,
	input  logic [rv_exec_pkg::XLEN-1:0] sumw_i,
	input  logic lt_i,
	input  logic eq_i,
	input  logic [rv_exec_pkg::XLEN-1:0] sll_i,
	input  logic [rv_exec_pkg::XLEN-1:0] sllw_i,
	input  logic [rv_exec_pkg::XLEN-1:0] sr_i,
	input  logic [rv_exec_pkg::XLEN-1:0] srw_i,
	output logic valid_o,
	output rv_exec_pkg::exec_resp_t resp_o
);

	logic [rv_exec_pkg::XLEN-1:0] opb;
	logic [rv_exec_pkg::XLEN-1:0] rd;
	logic taken;
	rv_exec_pkg::exec_resp_t resp_d;

	// logic ops share the compare operand select
	assign opb = ctrl_i.cmp_imm ? req_i.imm : req_i.rs2;

	always_comb begin
		case (ctrl_i.rd_sel)
			rv_exec_pkg::rd_addw: rd = sumw_i;
			rv_exec_pkg::rd_sll:  rd = sll_i;
			rv_exec_pkg::rd_sllw: rd = sllw_i;
			rv_exec_pkg::rd_sr:   rd = sr_i;
			rv_exec_pkg::rd_srw:  rd = srw_i;
			rv_exec_pkg::rd_lt:   rd = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt_i};
			rv_exec_pkg::rd_and:  rd = req_i.rs1 & opb;
			rv_exec_pkg::rd_or:   rd = req_i.rs1 | opb;
			rv_exec_pkg::rd_xor:  rd = req_i.rs1 ^ opb;
			rv_exec_pkg::rd_imm:  rd = req_i.imm;
			// return address
			rv_exec_pkg::rd_link: rd = {req_i.pcnext, 1'b0};
			default:              rd = sum_i;
		endcase
	end

	// beq/bne on eq, the other four on lt
	assign taken = ctrl_i.branch & (ctrl_i.branch_inv ^ (ctrl_i.branch_lt ? lt_i : eq_i));

	always_comb begin
		resp_d.sigill = ctrl_i.sigill;
		resp_d.rd = rd;
		resp_d.rd_write = ctrl_i.rd_write;
		// sum bit 0 dropped, clears the jalr target lsb
		resp_d.pcnext = (ctrl_i.jump | taken) ? sum_i[rv_exec_pkg::XLEN-1:1] : req_i.pcnext;
		resp_d.mem_load = ctrl_i.mem_load;
		resp_d.mem_store = ctrl_i.mem_store;
		resp_d.mem_funct3 = req_i.funct3;
		resp_d.mem_address = sum_i;
		resp_d.mem_store_value = req_i.rs2;
	end

	always_ff @(posedge clk) begin
		// payload only loads on a strobe
		if (valid_i)
			resp_o <= resp_d;
		// side-effect flags qualified by valid
		if (rst_i) begin
			valid_o <= 1'b0;
			resp_o.rd_write <= 1'b0;
			resp_o.mem_load <= 1'b0;
			resp_o.mem_store <= 1'b0;
		end else begin
			valid_o <= valid_i;
			resp_o.rd_write <= valid_i & resp_d.rd_write;
			resp_o.mem_load <= valid_i & resp_d.mem_load;
			resp_o.mem_store <= valid_i & resp_d.mem_store;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rv_shift.sv
/*
 * Logarithmic barrel shifter.
 * Gives 64-bit left and right shifts plus the word forms, which work on
 * the low half with a five bit amount and sign-extend the result.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_shift (
	input  logic [rv_exec_pkg::XLEN-1:0] value_i,
	input  logic [rv_exec_pkg::SHAMT_W-1:0] shamt_i,
	input  logic arith_i,
	output logic [rv_exec_pkg::XLEN-1:0] sll_o,
	output logic [rv_exec_pkg::XLEN-1:0] sllw_o,
	output logic [rv_exec_pkg::XLEN-1:0] sr_o,
	output logic [rv_exec_pkg::XLEN-1:0] srw_o
);

	logic [rv_exec_pkg::XLEN-1:0] sl;
	logic [rv_exec_pkg::XLEN-1:0] sr;
	logic [rv_exec_pkg::XLEN-1:0] sr_fill;
	logic [rv_exec_pkg::HALF_W-1:0] slw;
	logic [rv_exec_pkg::HALF_W-1:0] srw;
	logic [rv_exec_pkg::HALF_W-1:0] srw_fill;

	always_comb begin
		sl = value_i;
		sr = value_i;
		slw = value_i[rv_exec_pkg::HALF_W-1:0];
		srw = value_i[rv_exec_pkg::HALF_W-1:0];
		// all ones only for sra of a negative value
		sr_fill = {rv_exec_pkg::XLEN{arith_i & value_i[rv_exec_pkg::XLEN-1]}};
		srw_fill = {rv_exec_pkg::HALF_W{arith_i & value_i[rv_exec_pkg::HALF_W-1]}};
		// stage i shifts by 2**i
		for (int i = 0; i < rv_exec_pkg::SHAMT_W; i++)
			if (shamt_i[i]) begin
				sl = sl << (1 << i);
				sr = (sr >> (1 << i)) | (sr_fill & ~({rv_exec_pkg::XLEN{1'b1}} >> (1 << i)));
				// top amount bit is ignored by word forms
				if (i < rv_exec_pkg::SHAMT_W - 1) begin
					slw = slw << (1 << i);
					srw = (srw >> (1 << i)) |
						(srw_fill & ~({rv_exec_pkg::HALF_W{1'b1}} >> (1 << i)));
				end
			end
	end

	assign sll_o = sl;
	assign sr_o = sr;
	assign sllw_o = {{rv_exec_pkg::HALF_W{slw[rv_exec_pkg::HALF_W-1]}}, slw};
	assign srw_o = {{rv_exec_pkg::HALF_W{srw[rv_exec_pkg::HALF_W-1]}}, srw};

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_exec -f list.f -o sim
status=0
./obj_dir/sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: verification/rv_exec_assert.sv
/*
 * Protocol checks on the execute unit, bound into rv_exec.
 * Covers reset, the one-cycle valid latency and flag consistency.
 */
`timescale 1ns/1ns
`default_nettype none

module rv_exec_assert (
	input logic clk,
	input logic rst_i,
	input logic valid_i,
	input logic valid_o,
	input rv_exec_pkg::exec_resp_t resp_o
);

	// first cycle out of reset
	a_reset: assert property (@(posedge clk) $past(rst_i) |-> !valid_o)
		else $error("valid_o high right after reset");

	a_latency: assert property (@(posedge clk) disable iff (rst_i) valid_o == $past(valid_i))
		else $error("valid_o does not follow valid_i by one cycle");

	a_mem_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(resp_o.mem_load && resp_o.mem_store))
		else $error("load and store flagged together");

	// illegal instructions carry no side effects
	a_sigill: assert property (@(posedge clk) disable iff (rst_i)
		(valid_o && resp_o.sigill) |-> !(resp_o.rd_write || resp_o.mem_load || resp_o.mem_store))
		else $error("illegal instruction with side-effect flags set");

endmodule

bind rv_exec rv_exec_assert i_assert (.clk(clk), .rst_i(rst_i), .valid_i(valid_i),
	.valid_o(valid_o), .resp_o(resp_o));

`default_nettype wire

// File: verification/rv_exec_vectors.txt
# test opcode f3 f7 rs1 rs2 imm pc pcnext gap | sigill rd_write load store f3 rd pcnext addr store
# opcode is inst[6:2]; pc values are byte addresses; all but test and gap in hex
1 0c 0 00 5 7 0 1000 1004 0 0 1 0 0 0 c 1004 0 0
1 0c 0 20 5 7 0 1000 1004 0 0 1 0 0 0 fffffffffffffffe 1004 0 0
1 0c 2 00 fffffffffffffffe 1 0 1000 1004 0 0 1 0 0 2 1 1004 0 0
1 0c 3 00 fffffffffffffffe 1 0 1000 1004 0 0 1 0 0 3 0 1004 0 0
1 0c 7 00 f0f0 ff00 0 1000 1004 0 0 1 0 0 7 f000 1004 0 0
1 0c 6 00 f0f0 0f0f 0 1000 1004 0 0 1 0 0 6 ffff 1004 0 0
1 0c 4 00 ff ff0 0 1000 1004 0 0 1 0 0 4 f0f 1004 0 0
1 04 0 00 10 0 fffffffffffffff0 1000 1004 0 0 1 0 0 0 0 1004 0 0
1 04 3 00 3 0 ffffffffffffffff 1000 1004 0 0 1 0 0 3 1 1004 0 0
1 04 4 00 aa 0 ffffffffffffffff 1000 1004 1 0 1 0 0 4 ffffffffffffff55 1004 0 0
2 0e 0 00 7fffffff 1 0 1000 1004 0 0 1 0 0 0 ffffffff80000000 1004 0 0
2 0e 0 20 0 1 0 1000 1004 0 0 1 0 0 0 ffffffffffffffff 1004 0 0
2 06 0 00 100000005 0 3 1000 1004 0 0 1 0 0 0 8 1004 0 0
2 0e 1 00 1 1f 0 1000 1004 0 0 1 0 0 1 ffffffff80000000 1004 0 0
2 0e 5 00 ffffffff80000000 4 0 1000 1004 0 0 1 0 0 5 8000000 1004 0 0
2 0e 5 20 80000000 4 0 1000 1004 0 0 1 0 0 5 fffffffff8000000 1004 0 0
2 0c 1 00 1 41 0 1000 1004 0 0 1 0 0 1 2 1004 0 0
2 0c 5 00 8000000000000000 3f 0 1000 1004 0 0 1 0 0 5 1 1004 0 0
2 0c 5 20 8000000000000000 4 0 1000 1004 0 0 1 0 0 5 f800000000000000 1004 0 0
2 04 5 00 fffffffffffffff0 0 401 1000 1004 0 0 1 0 0 5 fffffffffffffff8 1004 0 0
2 06 1 00 0f000000 0 4 1000 1004 1 0 1 0 0 1 fffffffff0000000 1004 0 0
3 0d 0 00 0 0 12345000 1000 1004 0 0 1 0 0 0 12345000 1004 0 0
3 05 0 00 0 0 2000 1000 1004 0 0 1 0 0 0 3000 1004 0 0
3 18 0 00 5 5 40 1000 1004 0 0 0 0 0 0 0 1040 0 0
3 18 0 00 5 6 40 1000 1004 0 0 0 0 0 0 0 1004 0 0
3 18 1 00 5 6 fffffffffffffff0 1000 1004 0 0 0 0 0 1 0 ff0 0 0
3 18 4 00 ffffffffffffffff 1 8 1000 1004 0 0 0 0 0 4 0 1008 0 0
3 18 5 00 ffffffffffffffff 1 8 1000 1004 0 0 0 0 0 5 0 1004 0 0
3 18 6 00 ffffffffffffffff 1 8 1000 1004 0 0 0 0 0 6 0 1004 0 0
3 18 7 00 ffffffffffffffff 1 8 1000 1004 0 0 0 0 0 7 0 1008 0 0
3 1b 0 00 0 0 100 1000 1004 0 0 1 0 0 0 1004 1100 0 0
3 19 0 00 2001 0 4 1000 1004 1 0 1 0 0 0 1004 2004 0 0
4 00 3 00 8000 0 10 1000 1004 0 0 0 1 0 3 0 1004 8010 0
4 00 4 00 100 0 ffffffffffffffff 1000 1004 0 0 0 1 0 4 0 1004 ff 0
4 08 3 00 8000 deadbeef fffffffffffffff8 1000 1004 0 0 0 0 1 3 0 1004 7ff8 deadbeef
4 08 0 00 10 ab 1 1000 1004 1 0 0 0 1 0 0 1004 11 ab
5 00 7 00 0 0 0 1000 1004 0 1 0 0 0 7 0 1004 0 0
5 08 4 00 0 0 0 1000 1004 0 1 0 0 0 4 0 1004 0 0
5 18 2 00 0 0 40 1000 1004 0 1 0 0 0 2 0 1004 0 0
5 18 3 00 0 0 40 1000 1004 0 1 0 0 0 3 0 1004 0 0
5 0c 0 01 0 0 0 1000 1004 0 1 0 0 0 0 0 1004 0 0
5 0e 2 00 0 0 0 1000 1004 0 1 0 0 0 2 0 1004 0 0
5 04 1 00 0 0 40 1000 1004 0 1 0 0 0 1 0 1004 0 0
5 1c 0 00 0 0 0 1000 1004 0 1 0 0 0 0 0 1004 0 0
5 19 1 00 0 0 0 1000 1004 1 1 0 0 0 1 0 1004 0 0
6 0c 0 00 1 2 0 1000 1004 0 0 1 0 0 0 3 1004 0 0
6 0c 0 00 3 4 0 1000 1004 2 0 1 0 0 0 7 1004 0 0
6 04 0 00 a 0 1 1000 1004 0 0 1 0 0 0 b 1004 0 0
6 00 2 00 40 0 4 1000 1004 3 0 0 1 0 2 0 1004 44 0
6 0d 0 00 0 0 1000 1000 1004 1 0 1 0 0 0 1000 1004 0 0

// File: verification/tb_rv_exec.sv
/*
 * Testbench for the RV64 execute unit.
 * Reads request/response pairs from the vector file, strobes them into
 * the DUT with the listed gaps and checks every response one cycle later.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exec;

	typedef struct {
		int test;
		rv_exec_pkg::exec_req_t req;
		int gap;
		rv_exec_pkg::exec_resp_t resp;
	} vector_t;

	typedef struct {
		int test;
		rv_exec_pkg::exec_resp_t resp;
	} pending_t;

	logic clk;
	logic rst_i;
	logic valid_i;
	rv_exec_pkg::exec_req_t req_i;
	logic valid_o;
	rv_exec_pkg::exec_resp_t resp_o;

	vector_t vec_q[$];
	pending_t exp_q[$];
	int seed;
	int errors;
	int test_errs;
	int tests_run;
	int tests_failed;
	int cur_test;
	int max_gap;
	bit loaded;
	bit checking;
	logic strobed;
	longint limit_ns;

	rv_exec i_rv_exec (.clk(clk), .rst_i(rst_i), .valid_i(valid_i), .req_i(req_i),
		.valid_o(valid_o), .resp_o(resp_o));

	always #5 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		errors++;
		test_errs++;
	endtask

	// rd only when written, address only for memory ops, store value only for stores
	task automatic compare_data(input rv_exec_pkg::exec_resp_t got,
		input rv_exec_pkg::exec_resp_t exp);
		if (exp.rd_write && got.rd !== exp.rd)
			report_mismatch("resp_o.rd", got.rd, exp.rd);
		if (got.pcnext !== exp.pcnext)
			report_mismatch("resp_o.pcnext", {got.pcnext, 1'b0}, {exp.pcnext, 1'b0});
		if ((exp.mem_load || exp.mem_store) && got.mem_address !== exp.mem_address)
			report_mismatch("resp_o.mem_address", got.mem_address, exp.mem_address);
		if (exp.mem_store && got.mem_store_value !== exp.mem_store_value)
			report_mismatch("resp_o.mem_store_value", got.mem_store_value,
				exp.mem_store_value);
	endtask

	// full=0 on idle cycles, only the side-effect flags matter there
	task automatic compare_flags(input rv_exec_pkg::exec_resp_t got,
		input rv_exec_pkg::exec_resp_t exp, input bit full);
		if (got.rd_write !== exp.rd_write)
			report_mismatch("resp_o.rd_write", 64'(got.rd_write), 64'(exp.rd_write));
		if (got.mem_load !== exp.mem_load)
			report_mismatch("resp_o.mem_load", 64'(got.mem_load), 64'(exp.mem_load));
		if (got.mem_store !== exp.mem_store)
			report_mismatch("resp_o.mem_store", 64'(got.mem_store), 64'(exp.mem_store));
		if (full && got.sigill !== exp.sigill)
			report_mismatch("resp_o.sigill", 64'(got.sigill), 64'(exp.sigill));
		if (full && got.mem_funct3 !== exp.mem_funct3)
			report_mismatch("resp_o.mem_funct3", 64'(got.mem_funct3), 64'(exp.mem_funct3));
	endtask

	task automatic compare_valid(input logic got, input logic exp);
		if (got !== exp)
			report_mismatch("valid_o", 64'(got), 64'(exp));
	endtask

	task automatic finish_test();
		if (cur_test >= 0) begin
			$display("test %0d: %s, %0d errors", cur_test, test_errs ? "failed" : "passed",
				test_errs);
			tests_run++;
			if (test_errs != 0)
				tests_failed++;
		end
		test_errs = 0;
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		int t;
		int g;
		string line;
		logic [63:0] f[17];
		vector_t v;
		fd = $fopen("verification/rv_exec_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h %h %h %h",
					t, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], g, f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (n != 19) begin
					$display("vector line could not be parsed: %s", line);
					errors++;
					continue;
				end
				v.test = t;
				v.gap = g;
				v.req.opcode = rv_exec_pkg::opcode_e'(f[0][4:0]);
				v.req.funct3 = f[1][2:0];
				v.req.funct7 = f[2][6:0];
				v.req.rs1 = f[3];
				v.req.rs2 = f[4];
				v.req.imm = f[5];
				v.req.pc = f[6][63:1];
				v.req.pcnext = f[7][63:1];
				v.resp.sigill = f[8][0];
				v.resp.rd_write = f[9][0];
				v.resp.mem_load = f[10][0];
				v.resp.mem_store = f[11][0];
				v.resp.mem_funct3 = f[12][2:0];
				v.resp.rd = f[13];
				v.resp.pcnext = f[14][63:1];
				v.resp.mem_address = f[15];
				v.resp.mem_store_value = f[16];
				// register operands are don't-care for illegal encodings
				if (v.resp.sigill) begin
					v.req.rs1 = {$random(seed), $random(seed)};
					v.req.rs2 = {$random(seed), $random(seed)};
				end
				if (g > max_gap)
					max_gap = g;
				vec_q.push_back(v);
			end
			$fclose(fd);
		end
	endtask

	// valid_i only moves 1 ns after the edge, so sampling here is safe
	always @(posedge clk)
		strobed <= valid_i;

	// responses are stable at the falling edge
	always @(negedge clk) begin
		pending_t e;
		rv_exec_pkg::exec_resp_t idle;
		idle = '0;
		if (checking) begin
			compare_valid(valid_o, strobed);
			if (valid_o) begin
				if (exp_q.size() == 0) begin
					$display("response arrived with no request outstanding");
					errors++;
				end else begin
					e = exp_q.pop_front();
					if (e.test != cur_test) begin
						finish_test();
						cur_test = e.test;
					end
					compare_flags(resp_o, e.resp, 1'b1);
					compare_data(resp_o, e.resp);
				end
			end else
				compare_flags(resp_o, idle, 1'b0);
		end
	end

	// watchdog
	initial begin
		wait (loaded);
		limit_ns = longint'(vec_q.size()) * (max_gap + 20) * 10;
		#(limit_ns);
		$display("timeout: responses still outstanding after %0d ns", limit_ns);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		pending_t p;
		clk = 1'b0;
		rst_i = 1'b1;
		valid_i = 1'b0;
		req_i = '0;
		strobed = 1'b0;
		seed = 32'hd61c_aabb;
		errors = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = -1;
		max_gap = 0;
		checking = 1'b0;
		load_vectors();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst_i = 1'b0;
		checking = 1'b1;
		foreach (vec_q[i]) begin
			@(posedge clk);
			#1;
			valid_i = 1'b1;
			req_i = vec_q[i].req;
			p.test = vec_q[i].test;
			p.resp = vec_q[i].resp;
			exp_q.push_back(p);
			repeat (vec_q[i].gap) begin
				@(posedge clk);
				#1;
				valid_i = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		valid_i = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
		@(posedge clk);
		finish_test();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
